// File: design/rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes, inst[6:0]
    parameter logic [6:0] opLui    = 7'b0110111;
    parameter logic [6:0] opJal    = 7'b1101111;
    parameter logic [6:0] opBranch = 7'b1100011;
    parameter logic [6:0] opLoad   = 7'b0000011;
    parameter logic [6:0] opStore  = 7'b0100011;
    parameter logic [6:0] opImm    = 7'b0010011;
    parameter logic [6:0] opReg    = 7'b0110011;

    // ALU funct3
    parameter logic [2:0] f3Add  = 3'b000;
    parameter logic [2:0] f3Sll  = 3'b001;
    parameter logic [2:0] f3Slt  = 3'b010;
    parameter logic [2:0] f3Sltu = 3'b011;
    parameter logic [2:0] f3Xor  = 3'b100;
    parameter logic [2:0] f3Sr   = 3'b101;   // SRL or SRA by bit 30
    parameter logic [2:0] f3Or   = 3'b110;
    parameter logic [2:0] f3And  = 3'b111;

    // Branch funct3
    parameter logic [2:0] f3Beq = 3'b000;
    parameter logic [2:0] f3Bne = 3'b001;
    parameter logic [2:0] f3Blt = 3'b100;
    parameter logic [2:0] f3Bge = 3'b101;

    // Load and store sizes
    parameter logic [2:0] f3Byte  = 3'b000;
    parameter logic [2:0] f3Half  = 3'b001;
    parameter logic [2:0] f3Word  = 3'b010;
    parameter logic [2:0] f3ByteU = 3'b100;
    parameter logic [2:0] f3HalfU = 3'b101;

    // Field positions
    parameter int rdLsb  = 7;
    parameter int f3Lsb  = 12;
    parameter int rs1Lsb = 15;
    parameter int rs2Lsb = 20;
    parameter int altBit = 30;   // funct7 bit picking SUB and SRA

    parameter logic [31:0] nopInst = 32'h0000_0013;   // ADDI x0,x0,0

endpackage

// File: design/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB   // Operand B straight through, for LUI
    } aluOpT;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu,
        wbLoad,
        wbPc4
    } wbSelT;

    // Same coding as funct3 of loads and stores
    typedef logic [2:0] memSizeT;

endpackage

// File: design/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit #(
    parameter int imemWords = 256
) (
    input  logic        CLK,
    input  logic        rstN,
    input  logic [31:0] nextPc,
    input  logic        progWe,
    input  logic [31:0] progAddr,   // Byte address, like pc
    input  logic [31:0] progData,
    output logic [31:0] pc,
    output logic [31:0] inst
);
    localparam int idxW = $clog2(imemWords);   // Depth is a power of two

    logic [31:0]     imem [imemWords];
    logic [idxW-1:0] fetchIdx;
    logic [idxW-1:0] progIdx;

    assign fetchIdx = pc[idxW+1:2];   // Wraps modulo depth
    assign progIdx  = progAddr[idxW+1:2];
    assign inst     = imem[fetchIdx];

    // Empty slots execute as no-ops
    initial begin
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = rvIsaPkg::nopInst;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Loader port, live only while reset is held
    always @(posedge CLK) begin
        if (!rstN && progWe) begin
            imem[progIdx] <= progData;
        end
    end

endmodule

// File: design/instDecoder.sv
`timescale 1ns/1ns

module instDecoder (
    input  logic [31:0]         inst,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output logic [31:0]         imm,
    output cpuCtrlPkg::aluOpT   aluOp,
    output logic                aluSrcImm,
    output logic                regWrite,
    output logic                memWrite,
    output logic                isBranch,
    output logic                isJal,
    output logic [2:0]          brFunct,
    output cpuCtrlPkg::memSizeT memSize,
    output cpuCtrlPkg::wbSelT   wbSel
);
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              altFn;
    logic              writesRd;
    cpuCtrlPkg::aluOpT fnOp;   // ALU op implied by funct3

    assign opcode  = inst[6:0];
    assign funct3  = inst[rvIsaPkg::f3Lsb +: 3];
    assign altFn   = inst[rvIsaPkg::altBit];
    assign rs1     = inst[rvIsaPkg::rs1Lsb +: 5];
    assign rs2     = inst[rvIsaPkg::rs2Lsb +: 5];
    assign rd      = inst[rvIsaPkg::rdLsb +: 5];
    assign brFunct = funct3;
    assign memSize = funct3;

    // Shared by register and immediate forms
    always_comb begin
        case (funct3)
            rvIsaPkg::f3Add:  fnOp = cpuCtrlPkg::aluAdd;
            rvIsaPkg::f3Sll:  fnOp = cpuCtrlPkg::aluSll;
            rvIsaPkg::f3Slt:  fnOp = cpuCtrlPkg::aluSlt;
            rvIsaPkg::f3Sltu: fnOp = cpuCtrlPkg::aluSltu;
            rvIsaPkg::f3Xor:  fnOp = cpuCtrlPkg::aluXor;
            rvIsaPkg::f3Sr:   fnOp = altFn ? cpuCtrlPkg::aluSra : cpuCtrlPkg::aluSrl;
            rvIsaPkg::f3Or:   fnOp = cpuCtrlPkg::aluOr;
            default:          fnOp = cpuCtrlPkg::aluAnd;
        endcase
    end

    always_comb begin
        imm       = '0;
        aluOp     = cpuCtrlPkg::aluAdd;
        aluSrcImm = 1'b0;
        writesRd  = 1'b0;
        memWrite  = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        wbSel     = cpuCtrlPkg::wbAlu;
        case (opcode)
            rvIsaPkg::opReg: begin
                aluOp    = (funct3 == rvIsaPkg::f3Add && altFn) ? cpuCtrlPkg::aluSub : fnOp;
                writesRd = 1'b1;
            end
            rvIsaPkg::opImm: begin
                imm       = {{20{inst[31]}}, inst[31:20]};
                aluOp     = fnOp;   // ADDI never subtracts
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
            end
            rvIsaPkg::opLoad: begin
                imm       = {{20{inst[31]}}, inst[31:20]};
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
                wbSel     = cpuCtrlPkg::wbLoad;
            end
            rvIsaPkg::opStore: begin
                imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            rvIsaPkg::opBranch: begin
                imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                isBranch = 1'b1;
            end
            rvIsaPkg::opJal: begin
                imm      = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                isJal    = 1'b1;
                writesRd = 1'b1;
                wbSel    = cpuCtrlPkg::wbPc4;
            end
            rvIsaPkg::opLui: begin
                imm       = {inst[31:12], 12'b0};
                aluOp     = cpuCtrlPkg::aluPassB;
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
            end
            default: ;   // Unknown opcode, retires as a no-op
        endcase
    end

    assign regWrite = writesRd && (rd != 5'd0);   // x0 never reported as written

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic        CLK,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);
    logic [31:0] regs [32];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;   // x0 stays zero
        end
    end

    // Combinational reads, same cycle as decode
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: design/executeUnit.sv
`timescale 1ns/1ns

module executeUnit (
    input  logic [31:0]       pc,
    input  logic [31:0]       rdata1,
    input  logic [31:0]       rdata2,
    input  logic [31:0]       imm,
    input  cpuCtrlPkg::aluOpT aluOp,
    input  logic              aluSrcImm,
    input  logic              isBranch,
    input  logic              isJal,
    input  logic [2:0]        brFunct,
    output logic [31:0]       aluResult,
    output logic [31:0]       nextPc,
    output logic [31:0]       pcPlus4
);
    logic [31:0] opB;
    logic [4:0]  shamt;
    logic        brTaken;
    logic [31:0] target;

    assign opB   = aluSrcImm ? imm : rdata2;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            cpuCtrlPkg::aluAdd:   aluResult = rdata1 + opB;
            cpuCtrlPkg::aluSub:   aluResult = rdata1 - opB;
            cpuCtrlPkg::aluAnd:   aluResult = rdata1 & opB;
            cpuCtrlPkg::aluOr:    aluResult = rdata1 | opB;
            cpuCtrlPkg::aluXor:   aluResult = rdata1 ^ opB;
            cpuCtrlPkg::aluSlt:   aluResult = {31'b0, $signed(rdata1) < $signed(opB)};
            cpuCtrlPkg::aluSltu:  aluResult = {31'b0, rdata1 < opB};
            cpuCtrlPkg::aluSll:   aluResult = rdata1 << shamt;
            cpuCtrlPkg::aluSrl:   aluResult = rdata1 >> shamt;
            cpuCtrlPkg::aluSra:   aluResult = $unsigned($signed(rdata1) >>> shamt);
            cpuCtrlPkg::aluPassB: aluResult = opB;
            default:              aluResult = '0;
        endcase
    end

    // Branch compare always on the two registers
    always_comb begin
        case (brFunct)
            rvIsaPkg::f3Beq: brTaken = (rdata1 == rdata2);
            rvIsaPkg::f3Bne: brTaken = (rdata1 != rdata2);
            rvIsaPkg::f3Blt: brTaken = ($signed(rdata1) < $signed(rdata2));
            rvIsaPkg::f3Bge: brTaken = ($signed(rdata1) >= $signed(rdata2));
            default:         brTaken = 1'b0;   // BLTU/BGEU not supported
        endcase
    end

    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + imm;   // Branch or JAL destination
    assign nextPc  = ((isBranch && brTaken) || isJal) ? target : pcPlus4;

endmodule

// File: design/dataMemory.sv
`timescale 1ns/1ns

module dataMemory #(
    parameter int dmemWords = 256
) (
    input  logic                CLK,
    input  logic [31:0]         addr,
    input  logic [31:0]         wdata,
    input  logic                we,
    input  cpuCtrlPkg::memSizeT memSize,
    output logic [31:0]         loadWord,
    output logic [3:0]          storeMask
);
    localparam int idxW = $clog2(dmemWords);   // Depth is a power of two

    logic [31:0]     dmem [dmemWords];
    logic [idxW-1:0] wordIdx;
    logic [31:0]     laneData;
    logic [3:0]      sizeMask;

    assign wordIdx  = addr[idxW+1:2];   // Wraps modulo depth
    assign loadWord = dmem[wordIdx];

    initial begin
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = '0;
        end
    end

    // Move store data into its byte lanes
    always_comb begin
        if (memSize == rvIsaPkg::f3Byte) begin
            sizeMask = 4'b0001 << addr[1:0];
            laneData = wdata << {addr[1:0], 3'b000};
        end else if (memSize == rvIsaPkg::f3Half) begin
            sizeMask = 4'b0011 << {addr[1], 1'b0};
            laneData = wdata << {addr[1], 4'b0000};
        end else begin
            sizeMask = 4'b1111;
            laneData = wdata;
        end
    end

    assign storeMask = we ? sizeMask : 4'b0000;

    always @(posedge CLK) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (storeMask[lane]) begin
                dmem[wordIdx][lane*8 +: 8] <= laneData[lane*8 +: 8];
            end
        end
    end

endmodule

// File: design/writeBack.sv
`timescale 1ns/1ns

module writeBack (
    input  logic [31:0]         aluResult,
    input  logic [31:0]         loadWord,
    input  logic [31:0]         pcPlus4,
    input  cpuCtrlPkg::memSizeT memSize,
    input  cpuCtrlPkg::wbSelT   wbSel,
    output logic [31:0]         wbData
);
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    logic [31:0] loadVal;

    // Pick the addressed lane
    assign loadByte = loadWord[{aluResult[1:0], 3'b000} +: 8];
    assign loadHalf = aluResult[1] ? loadWord[31:16] : loadWord[15:0];

    always_comb begin
        case (memSize)
            rvIsaPkg::f3Byte:  loadVal = {{24{loadByte[7]}}, loadByte};
            rvIsaPkg::f3ByteU: loadVal = {24'b0, loadByte};
            rvIsaPkg::f3Half:  loadVal = {{16{loadHalf[15]}}, loadHalf};
            rvIsaPkg::f3HalfU: loadVal = {16'b0, loadHalf};
            default:           loadVal = loadWord;   // LW
        endcase
    end

    always_comb begin
        case (wbSel)
            cpuCtrlPkg::wbLoad: wbData = loadVal;
            cpuCtrlPkg::wbPc4:  wbData = pcPlus4;   // JAL link
            default:            wbData = aluResult;
        endcase
    end

endmodule

// File: design/singleCpu.sv
`timescale 1ns/1ns

module singleCpu #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic        CLK,
    input  logic        rstN,
    input  logic        progWe,
    input  logic [31:0] progAddr,
    input  logic [31:0] progData,
    output logic        retireValid,
    output logic [31:0] retirePc,
    output logic        retireRegWrite,
    output logic [4:0]  retireRd,
    output logic [31:0] retireData,
    output logic        storeEn,
    output logic [31:0] storeAddr,
    output logic [31:0] storeData,
    output logic [3:0]  storeMask
);
    logic [31:0]         pc, inst, nextPc, pcPlus4;
    logic [4:0]          rs1, rs2, rd;
    logic [31:0]         imm, rdata1, rdata2;
    logic [31:0]         aluResult, loadWord, wbData;
    cpuCtrlPkg::aluOpT   aluOp;
    cpuCtrlPkg::memSizeT memSize;
    cpuCtrlPkg::wbSelT   wbSel;
    logic                aluSrcImm, regWrite, memWrite, isBranch, isJal;
    logic [2:0]          brFunct;

    fetchUnit #(.imemWords(imemWords)) i_fetch (
        .CLK(CLK), .rstN(rstN), .nextPc(nextPc), .progWe(progWe),
        .progAddr(progAddr), .progData(progData), .pc(pc), .inst(inst));

    instDecoder i_decode (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .regWrite(regWrite), .memWrite(memWrite),
        .isBranch(isBranch), .isJal(isJal), .brFunct(brFunct),
        .memSize(memSize), .wbSel(wbSel));

    regFile i_regs (
        .CLK(CLK), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd), .we(regWrite),
        .wdata(wbData), .rdata1(rdata1), .rdata2(rdata2));

    executeUnit i_exec (
        .pc(pc), .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch), .isJal(isJal), .brFunct(brFunct),
        .aluResult(aluResult), .nextPc(nextPc), .pcPlus4(pcPlus4));

    dataMemory #(.dmemWords(dmemWords)) i_dmem (
        .CLK(CLK), .addr(aluResult), .wdata(rdata2), .we(memWrite), .memSize(memSize),
        .loadWord(loadWord), .storeMask(storeMask));

    writeBack i_wb (
        .aluResult(aluResult), .loadWord(loadWord), .pcPlus4(pcPlus4),
        .memSize(memSize), .wbSel(wbSel), .wbData(wbData));

    // Retire report for the instruction in flight
    assign retireValid    = rstN;
    assign retirePc       = pc;
    assign retireRegWrite = regWrite;
    assign retireRd       = rd;
    assign retireData     = wbData;
    assign storeEn        = memWrite;
    assign storeAddr      = aluResult;
    assign storeData      = rdata2;   // Unshifted register value

endmodule

// File: test/rvModel.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// Architectural state of the reference model
localparam int modelMemWords = 64;

logic [31:0] mPc;
logic [31:0] mRegs [32];
logic [31:0] mMem [modelMemWords];

// Expected retire report for the instruction at mPc
logic        expRegWrite;
logic [4:0]  expRd;
logic [31:0] expData;
logic        expStoreEn;
logic [31:0] expStoreAddr;
logic [31:0] expStoreData;
logic [3:0]  expStoreMask;

task automatic modelReset();
    mPc = 32'd0;
    for (int i = 0; i < 32; i++) begin
        mRegs[i] = 32'd0;
    end
    for (int i = 0; i < modelMemWords; i++) begin
        mMem[i] = 32'd0;
    end
endtask

// RV32I arithmetic, alt is instruction bit 30
function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic isReg,
                                         logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'b000: return (isReg && alt) ? a - b : a + b;
        3'b001: return a << sh;
        3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: return (a < b) ? 32'd1 : 32'd0;
        3'b100: return a ^ b;
        3'b101: return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// Execute one instruction, fill the expected report, commit state
task automatic modelStep(input logic [31:0] inst);
    logic [6:0]  op;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] jImm;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] val;
    logic [31:0] nPc;
    logic        wr;
    logic        taken;
    int          idx;
    int          lane;
    op   = inst[6:0];
    rd   = inst[11:7];
    f3   = inst[14:12];
    a    = mRegs[inst[19:15]];
    b    = mRegs[inst[24:20]];
    iImm = {{20{inst[31]}}, inst[31:20]};
    sImm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    bImm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    jImm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    nPc  = mPc + 32'd4;
    wr   = 1'b0;
    val  = 32'd0;
    expStoreEn   = 1'b0;
    expStoreAddr = 32'd0;
    expStoreData = 32'd0;
    expStoreMask = 4'b0000;
    case (op)
        rvIsaPkg::opReg: begin
            val = aluModel(f3, inst[30], 1'b1, a, b);
            wr  = 1'b1;
        end
        rvIsaPkg::opImm: begin
            val = aluModel(f3, inst[30], 1'b0, a, iImm);
            wr  = 1'b1;
        end
        rvIsaPkg::opLui: begin
            val = {inst[31:12], 12'd0};
            wr  = 1'b1;
        end
        rvIsaPkg::opLoad: begin
            addr    = a + iImm;
            idx     = int'(addr >> 2) % modelMemWords;
            lane    = int'(addr[1:0]);
            word    = mMem[idx];
            shifted = word >> (8 * lane);
            case (f3)
                3'b000:  val = {{24{shifted[7]}}, shifted[7:0]};
                3'b100:  val = {24'd0, shifted[7:0]};
                3'b001:  val = {{16{shifted[15]}}, shifted[15:0]};
                3'b101:  val = {16'd0, shifted[15:0]};
                default: val = word;
            endcase
            wr = 1'b1;
        end
        rvIsaPkg::opStore: begin
            addr = a + sImm;
            idx  = int'(addr >> 2) % modelMemWords;
            lane = int'(addr[1:0]);
            if (f3 == 3'b000) begin
                expStoreMask = 4'b0001 << lane;
                shifted      = b << (8 * lane);
            end else if (f3 == 3'b001) begin
                expStoreMask = 4'b0011 << (lane & 2);
                shifted      = b << (8 * (lane & 2));
            end else begin
                expStoreMask = 4'b1111;
                shifted      = b;
            end
            for (int k = 0; k < 4; k++) begin
                if (expStoreMask[k]) begin
                    mMem[idx][k*8 +: 8] = shifted[k*8 +: 8];
                end
            end
            expStoreEn   = 1'b1;
            expStoreAddr = addr;
            expStoreData = b;
        end
        rvIsaPkg::opBranch: begin
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                default: taken = 1'b0;
            endcase
            if (taken) begin
                nPc = mPc + bImm;
            end
        end
        rvIsaPkg::opJal: begin
            val = mPc + 32'd4;
            wr  = 1'b1;
            nPc = mPc + jImm;
        end
        default: ;   // Unknown opcode, nothing changes
    endcase
    expRegWrite = wr && (rd != 5'd0);
    expRd       = rd;
    expData     = val;
    if (expRegWrite) begin
        mRegs[rd] = val;
    end
    mPc = nPc;
endtask

`endif

// File: test/singleCpuTb.sv
`timescale 1ns/1ns

module singleCpuTb;

    localparam int progWords  = 64;
    localparam int runLength  = 600;
    localparam int cycleLimit = 700;   // Load plus run plus margin

    logic        CLK = 1'b0;
    logic        rstN;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic        retireValid;
    logic [31:0] retirePc;
    logic        retireRegWrite;
    logic [4:0]  retireRd;
    logic [31:0] retireData;
    logic        storeEn;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    logic [3:0]  storeMask;

    logic [31:0] prog [progWords];
    logic [31:0] rngState;
    int          cycleCount = 0;

    `include "rvModel.svh"

    singleCpu #(.imemWords(64), .dmemWords(64)) i_dut (
        .CLK(CLK), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .retireValid(retireValid), .retirePc(retirePc),
        .retireRegWrite(retireRegWrite), .retireRd(retireRd), .retireData(retireData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
        .storeMask(storeMask));

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] encodeBranch(logic [2:0] f3, logic [4:0] rs1,
                                                 logic [4:0] rs2, logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] encodeJal(logic [4:0] rd, logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
    endfunction

    // One random instruction for the given slot
    function automatic logic [31:0] randomInst(int slot);
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [6:0]  funct7;
        logic [2:0]  loadSizes [5];
        int          kind;
        int          span;
        int          off;
        kind      = int'(nextRand() % 16);
        rnd       = nextRand();
        rd        = {2'b00, rnd[2:0]};   // x0 to x7 only
        rs1       = {2'b00, rnd[5:3]};
        rs2       = {2'b00, rnd[8:6]};
        f3        = rnd[11:9];
        imm12     = rnd[31:20];
        loadSizes = '{rvIsaPkg::f3Byte, rvIsaPkg::f3Half, rvIsaPkg::f3Word,
                      rvIsaPkg::f3ByteU, rvIsaPkg::f3HalfU};
        span      = (progWords - 1 - slot) < 4 ? (progWords - 1 - slot) : 4;
        off       = 4 * (1 + int'(rnd[14:13]) % span);   // Forward jump that stays before last slot
        if (kind == 0) begin
            return {rnd[31:7], 7'b0001011};   // Unused opcode
        end else if (kind <= 4) begin
            funct7 = (f3 == rvIsaPkg::f3Add || f3 == rvIsaPkg::f3Sr) ?
                     {1'b0, rnd[12], 5'b0} : 7'b0;
            return {funct7, rs2, rs1, f3, rd, rvIsaPkg::opReg};
        end else if (kind <= 7) begin
            if (f3 == rvIsaPkg::f3Sll) begin
                imm12 = {7'b0, rnd[24:20]};
            end else if (f3 == rvIsaPkg::f3Sr) begin
                imm12 = {1'b0, rnd[12], 5'b0, rnd[24:20]};
            end
            return {imm12, rs1, f3, rd, rvIsaPkg::opImm};
        end else if (kind == 8) begin
            return {rnd[31:12], rd, rvIsaPkg::opLui};
        end else if (kind <= 10) begin
            f3    = loadSizes[int'(rnd[15:13]) % 5];
            imm12 = {4'b0, rnd[27:20]};
            if (f3 == rvIsaPkg::f3Word) begin
                imm12[1:0] = 2'b00;
            end else if (f3 == rvIsaPkg::f3Half || f3 == rvIsaPkg::f3HalfU) begin
                imm12[0] = 1'b0;
            end
            return {imm12, 5'd0, f3, rd, rvIsaPkg::opLoad};
        end else if (kind <= 12) begin
            f3    = loadSizes[int'(rnd[14:13]) % 3];
            imm12 = {4'b0, rnd[27:20]};
            if (f3 == rvIsaPkg::f3Word) begin
                imm12[1:0] = 2'b00;
            end else if (f3 == rvIsaPkg::f3Half) begin
                imm12[0] = 1'b0;
            end
            return {imm12[11:5], rs2, 5'd0, f3, imm12[4:0], rvIsaPkg::opStore};
        end else if (kind <= 14) begin
            case (rnd[10:9])
                2'd0:    f3 = rvIsaPkg::f3Beq;
                2'd1:    f3 = rvIsaPkg::f3Bne;
                2'd2:    f3 = rvIsaPkg::f3Blt;
                default: f3 = rvIsaPkg::f3Bge;
            endcase
            return encodeBranch(f3, rs1, rs2, 32'(off));
        end
        return encodeJal(rd, 32'(off));
    endfunction

    task automatic buildProgram();
        logic [31:0] linkRnd;
        for (int i = 0; i < progWords - 1; i++) begin
            prog[i] = randomInst(i);
        end
        // Close the loop back to address 0
        linkRnd = nextRand();
        prog[progWords-1] = encodeJal({2'b00, linkRnd[2:0]}, -32'(4 * (progWords - 1)));
    endtask

    task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        rstN     = 1'b0;
        progWe   = 1'b0;
        progAddr = 32'd0;
        progData = 32'd0;
        rngState = 32'd13;
        buildProgram();
        modelReset();

        // Program load while reset is held
        for (int i = 0; i < progWords; i++) begin
            @(posedge CLK);
            #2;
            progWe   = 1'b1;
            progAddr = 32'(4 * i);
            progData = prog[i];
            checkVal("retireValid", {31'd0, retireValid}, 32'd0);
        end
        @(posedge CLK);
        #2;
        progWe = 1'b0;
        rstN   = 1'b1;

        // Lockstep with the model at the falling edge
        for (int n = 0; n < runLength; n++) begin
            @(negedge CLK);
            checkVal("retireValid", {31'd0, retireValid}, 32'd1);
            checkVal("retirePc", retirePc, mPc);
            modelStep(prog[int'(mPc >> 2) % progWords]);
            checkVal("retireRegWrite", {31'd0, retireRegWrite}, {31'd0, expRegWrite});
            if (expRegWrite) begin
                checkVal("retireRd", {27'd0, retireRd}, {27'd0, expRd});
                checkVal("retireData", retireData, expData);
            end
            checkVal("storeEn", {31'd0, storeEn}, {31'd0, expStoreEn});
            checkVal("storeMask", {28'd0, storeMask}, {28'd0, expStoreMask});
            if (expStoreEn) begin
                checkVal("storeAddr", storeAddr, expStoreAddr);
                checkVal("storeData", storeData, expStoreData);
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+test
design/rvIsaPkg.sv
design/cpuCtrlPkg.sv
design/fetchUnit.sv
design/instDecoder.sv
design/regFile.sv
design/executeUnit.sv
design/dataMemory.sv
design/writeBack.sv
design/singleCpu.sv
test/singleCpuTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module singleCpuTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

out=$(./obj_dir/VsingleCpuTb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "Pass message not found"
exit 1
